/* menuPkg.sv */
`default_nettype none

package menuPkg;

	////////////////////
	// Widths
	////////////////////
	localparam int charW = 8;
	localparam int lcdAddrW = 5;
	localparam int colW = 4;
	localparam int lineLen = 16;
	localparam int screenLen = 32;
	localparam int menuW = 4;
	localparam int srcW = 2;
	localparam int stateW = 4;

	// Fill code and first code offered in edit
	localparam logic [charW-1:0] spaceChar = 8'h20;
	localparam logic [charW-1:0] editInitChar = 8'h41;

	////////////////////
	// Menu text codes
	////////////////////
	localparam logic [menuW-1:0] menuMain = 4'd0;
	localparam logic [menuW-1:0] menuDisplayMaster = 4'd1;
	localparam logic [menuW-1:0] menuDisplayRam = 4'd2;
	localparam logic [menuW-1:0] menuModifyRam = 4'd3;
	localparam logic [menuW-1:0] menuClearRam = 4'd4;
	localparam logic [menuW-1:0] menuSlaveActions = 4'd5;
	localparam logic [menuW-1:0] menuAreYouSure = 4'd6;
	localparam logic [menuW-1:0] menuYes = 4'd8;
	localparam logic [menuW-1:0] menuNo = 4'd9;

	// Byte source for an LCD refresh
	localparam logic [srcW-1:0] srcMenu = 2'd0;
	localparam logic [srcW-1:0] srcMaster = 2'd1;
	localparam logic [srcW-1:0] srcSlave = 2'd2;
	localparam logic [srcW-1:0] srcEdit = 2'd3;

	////////////////////
	// Menu FSM states
	////////////////////
	localparam logic [stateW-1:0] stTitle = 4'd0;
	localparam logic [stateW-1:0] stOption = 4'd1;
	localparam logic [stateW-1:0] stWaitSel = 4'd2;
	localparam logic [stateW-1:0] stShow = 4'd3;
	localparam logic [stateW-1:0] stWaitBack = 4'd4;
	localparam logic [stateW-1:0] stPosSel = 4'd5;
	localparam logic [stateW-1:0] stCharSel = 4'd6;
	localparam logic [stateW-1:0] stConfirm = 4'd7;

endpackage

`default_nettype wire

/* menuRom.sv */
`timescale 1ns/1ps
`default_nettype none

module menuRom (
	input wire logic [menuPkg::menuW-1:0] menu,
	input wire logic [menuPkg::colW-1:0] col,
	output logic [menuPkg::charW-1:0] chr
);
	import menuPkg::*;

	// One full text line, first character in the top byte
	logic [charW*lineLen-1:0] text;
	// Column counted from the low end of the line
	logic [colW-1:0] colRev;

	////////////////////
	// Text lines
	////////////////////
	always_comb begin
		case (menu)
			menuMain:
				text = "MAIN MENU       ";
			menuDisplayMaster:
				text = "DISPLAY MASTER  ";
			menuDisplayRam:
				text = "DISPLAY RAM     ";
			menuModifyRam:
				text = "MODIFY RAM      ";
			menuClearRam:
				text = "CLEAR RAM       ";
			menuSlaveActions:
				text = "SLAVE ACTIONS   ";
			menuAreYouSure:
				text = "ARE YOU SURE?   ";
			menuYes:
				text = "YES             ";
			menuNo:
				text = "NO              ";
			// Unused codes show a blank line
			default:
				text = "                ";
		endcase
	end

	// Pick one byte out of the line
	assign colRev = colW'(lineLen - 1) - col;
	assign chr = text[colRev*charW +: charW];

endmodule

`default_nettype wire

/* charRam.sv */
`timescale 1ns/1ps
`default_nettype none

module charRam (
	input wire logic clk,
	input wire logic rstN,
	input wire logic we,
	input wire logic [menuPkg::lcdAddrW-1:0] waddr,
	input wire logic [menuPkg::charW-1:0] wdata,
	input wire logic clear,
	input wire logic [menuPkg::lcdAddrW-1:0] raddr,
	output logic [menuPkg::charW-1:0] rdata,
	input wire logic [menuPkg::lcdAddrW-1:0] caddr,
	output logic [menuPkg::charW-1:0] cdata
);
	import menuPkg::*;

	logic [charW-1:0] mem [screenLen];

	// Reset and clear both fill every cell with spaces in one edge
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			for (int i = 0; i < screenLen; i++) begin
				mem[i] <= spaceChar;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered port for the LCD path
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

	// Combinational port
	assign cdata = mem[caddr];

endmodule

`default_nettype wire

/* charStore.sv */
`timescale 1ns/1ps
`default_nettype none

module charStore (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [menuPkg::srcW-1:0] rdSrc,
	input wire logic [menuPkg::menuW-1:0] rdMenu,
	input wire logic [menuPkg::lcdAddrW-1:0] rdAddr,
	output logic [menuPkg::charW-1:0] rdData,
	input wire logic [menuPkg::lcdAddrW-1:0] masterWaddr,
	input wire logic [menuPkg::charW-1:0] masterWdata,
	input wire logic masterWe,
	input wire logic slaveWe,
	input wire logic [menuPkg::lcdAddrW-1:0] slaveWaddr,
	input wire logic [menuPkg::charW-1:0] slaveWdata,
	input wire logic slaveClear,
	input wire logic [menuPkg::lcdAddrW-1:0] slaveRaddr,
	output logic [menuPkg::charW-1:0] slaveRdata
);
	import menuPkg::*;

	logic [charW-1:0] romChr;
	logic [charW-1:0] romQ;
	logic [charW-1:0] masterRd;
	logic [charW-1:0] slaveRd;
	// Source of the byte fetched last cycle
	logic [srcW-1:0] srcQ;

	// Menu column is the LCD address modulo the line length
	menuRom uMenuRom (
		.menu(rdMenu),
		.col(rdAddr[colW-1:0]),
		.chr(romChr)
	);

	// Written by the I2C master, never cleared
	charRam uMasterRam (
		.clk(clk),
		.rstN(rstN),
		.we(masterWe),
		.waddr(masterWaddr),
		.wdata(masterWdata),
		.clear(1'b0),
		.raddr(rdAddr),
		.rdata(masterRd),
		.caddr(rdAddr),
		.cdata()
	);

	// Edited from the panel, read by the I2C master
	charRam uSlaveRam (
		.clk(clk),
		.rstN(rstN),
		.we(slaveWe),
		.waddr(slaveWaddr),
		.wdata(slaveWdata),
		.clear(slaveClear),
		.raddr(rdAddr),
		.rdata(slaveRd),
		.caddr(slaveRaddr),
		.cdata(slaveRdata)
	);

	// ROM byte registered to line up with the RAM read ports
	always_ff @(posedge clk) begin
		romQ <= romChr;
		srcQ <= rdSrc;
	end

	always_comb begin
		case (srcQ)
			srcMenu: rdData = romQ;
			srcMaster: rdData = masterRd;
			default: rdData = slaveRd;
		endcase
	end

endmodule

`default_nettype wire

/* lcdSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lcdSequencer (
	input wire logic clk,
	input wire logic rstN,
	input wire logic seqStart,
	input wire logic [menuPkg::srcW-1:0] seqSrc,
	input wire logic [menuPkg::menuW-1:0] seqMenu,
	input wire logic [menuPkg::lcdAddrW-1:0] seqFirst,
	input wire logic [menuPkg::lcdAddrW-1:0] seqLast,
	input wire logic [menuPkg::charW-1:0] editChar,
	input wire logic [menuPkg::charW-1:0] rdData,
	output logic [menuPkg::srcW-1:0] rdSrc,
	output logic [menuPkg::menuW-1:0] rdMenu,
	output logic [menuPkg::lcdAddrW-1:0] rdAddr,
	output logic [menuPkg::lcdAddrW-1:0] lcdWadd,
	output logic [menuPkg::charW-1:0] lcdDin,
	output logic lcdW,
	output logic seqDone
);
	import menuPkg::*;

	// Loop control
	logic busy;
	logic writePhase;
	// Range and source captured at start
	logic [lcdAddrW-1:0] addr;
	logic [lcdAddrW-1:0] lastQ;
	logic [srcW-1:0] srcQ;
	logic [menuW-1:0] menuQ;

	// Start cycle doubles as the first fetch
	assign rdSrc = busy ? srcQ : seqSrc;
	assign rdMenu = busy ? menuQ : seqMenu;
	assign rdAddr = busy ? addr : seqFirst;

	// Write cycle
	assign lcdW = busy && writePhase;
	assign lcdWadd = addr;
	assign lcdDin = (srcQ == srcEdit) ? editChar : rdData;

	////////////////////
	// Fetch and write loop
	////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			writePhase <= 1'b0;
			seqDone <= 1'b0;
		end else begin
			seqDone <= 1'b0;
			if (!busy) begin
				if (seqStart) begin
					busy <= 1'b1;
					writePhase <= 1'b1;
					addr <= seqFirst;
					lastQ <= seqLast;
					srcQ <= seqSrc;
					menuQ <= seqMenu;
				end
			end else if (writePhase) begin
				// Stop after the last address is written
				if (addr == lastQ) begin
					busy <= 1'b0;
					writePhase <= 1'b0;
					seqDone <= 1'b1;
				end else begin
					addr <= addr + 1'b1;
					writePhase <= 1'b0;
				end
			end else begin
				writePhase <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* menuFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module menuFsm (
	input wire logic clk,
	input wire logic rstN,
	input wire logic rotaryEvent,
	input wire logic rotaryLeft,
	input wire logic rotaryBtn,
	input wire logic menuBtn,
	input wire logic seqDone,
	output logic seqStart,
	output logic [menuPkg::srcW-1:0] seqSrc,
	output logic [menuPkg::menuW-1:0] seqMenu,
	output logic [menuPkg::lcdAddrW-1:0] seqFirst,
	output logic [menuPkg::lcdAddrW-1:0] seqLast,
	output logic [menuPkg::charW-1:0] editChar,
	output logic slaveWe,
	output logic [menuPkg::lcdAddrW-1:0] slaveWaddr,
	output logic [menuPkg::charW-1:0] slaveWdata,
	output logic slaveClear,
	output logic editActive
);
	import menuPkg::*;

	logic [stateW-1:0] state;
	logic [menuW-1:0] option;
	logic [lcdAddrW-1:0] pos;
	// This state already launched its sequence
	logic issued;
	// Sequencer running, tracked across menuBtn
	logic seqBusy;
	logic seqIdle;
	logic isConfirm;

	// Main option ring, left steps forward
	function automatic logic [menuW-1:0] stepOption(input logic [menuW-1:0] opt,
			input logic left);
		logic [menuW-1:0] res;
		case (opt)
			menuDisplayMaster: res = left ? menuDisplayRam : menuSlaveActions;
			menuDisplayRam: res = left ? menuModifyRam : menuDisplayMaster;
			menuModifyRam: res = left ? menuClearRam : menuDisplayRam;
			menuClearRam: res = left ? menuSlaveActions : menuModifyRam;
			menuSlaveActions: res = left ? menuDisplayMaster : menuClearRam;
			default: res = menuDisplayMaster;
		endcase
		return res;
	endfunction

	assign seqIdle = !seqBusy && !seqStart;
	assign isConfirm = (option == menuYes) || (option == menuNo);
	assign editActive = (state == stPosSel);
	assign slaveWaddr = pos;
	assign slaveWdata = editChar;

	////////////////////
	// Sequence request per state
	////////////////////
	always_comb begin
		seqSrc = srcMenu;
		seqMenu = menuMain;
		seqFirst = '0;
		seqLast = lcdAddrW'(screenLen - 1);
		case (state)
			stTitle: begin
				seqMenu = isConfirm ? menuAreYouSure : menuMain;
				seqLast = lcdAddrW'(lineLen - 1);
			end
			stOption: begin
				seqMenu = option;
				seqFirst = lcdAddrW'(lineLen);
			end
			stShow:
				seqSrc = (option == menuDisplayMaster) ? srcMaster : srcSlave;
			// Single cell at the edit position
			stCharSel: begin
				seqSrc = srcEdit;
				seqFirst = pos;
				seqLast = pos;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			seqBusy <= 1'b0;
		end else if (seqStart) begin
			seqBusy <= 1'b1;
		end else if (seqDone) begin
			seqBusy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN || menuBtn) begin
			state <= stTitle;
			option <= menuDisplayMaster;
			pos <= '0;
			editChar <= editInitChar;
			issued <= 1'b0;
			seqStart <= 1'b0;
			slaveWe <= 1'b0;
			slaveClear <= 1'b0;
		end else begin
			seqStart <= 1'b0;
			slaveWe <= 1'b0;
			slaveClear <= 1'b0;
			case (state)
				// Refresh states launch once, then wait for done
				stTitle, stOption, stShow: begin
					if (!issued) begin
						if (seqIdle) begin
							seqStart <= 1'b1;
							issued <= 1'b1;
						end
					end else if (seqDone) begin
						issued <= 1'b0;
						if (state == stTitle) begin
							state <= stOption;
						end else if (state == stOption) begin
							state <= isConfirm ? stConfirm : stWaitSel;
						end else begin
							state <= (option == menuModifyRam) ? stPosSel : stWaitBack;
						end
					end
				end
				stWaitSel: begin
					if (rotaryEvent) begin
						option <= stepOption(option, rotaryLeft);
						state <= stTitle;
					end else if (rotaryBtn) begin
						case (option)
							menuDisplayMaster, menuDisplayRam, menuModifyRam:
								state <= stShow;
							menuClearRam: begin
								option <= menuYes;
								state <= stTitle;
							end
							// Slave actions has no submenu
							default: ;
						endcase
					end
				end
				// YES and NO toggle
				stConfirm: begin
					if (rotaryEvent) begin
						option <= (option == menuYes) ? menuNo : menuYes;
						state <= stTitle;
					end else if (rotaryBtn) begin
						slaveClear <= (option == menuYes);
						option <= menuDisplayMaster;
						state <= stTitle;
					end
				end
				stWaitBack:
					if (rotaryBtn) begin
						state <= stTitle;
					end
				stPosSel: begin
					if (rotaryEvent) begin
						pos <= rotaryLeft ? pos + 1'b1 : pos - 1'b1;
					end else if (rotaryBtn) begin
						state <= stCharSel;
					end
				end
				stCharSel: begin
					if (issued) begin
						if (seqDone) begin
							issued <= 1'b0;
						end
					end else if (seqIdle) begin
						// Each step redraws the cell
						if (rotaryEvent) begin
							editChar <= rotaryLeft ? editChar + 1'b1 : editChar - 1'b1;
							seqStart <= 1'b1;
							issued <= 1'b1;
						end else if (rotaryBtn) begin
							slaveWe <= 1'b1;
							state <= stPosSel;
						end
					end
				end
				default:
					state <= stTitle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* menuCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module menuCtrl (
	input wire logic clk,
	input wire logic rstN,
	input wire logic rotaryEvent,
	input wire logic rotaryLeft,
	input wire logic rotaryBtn,
	input wire logic menuBtn,
	input wire logic [menuPkg::lcdAddrW-1:0] masterWaddr,
	input wire logic [menuPkg::charW-1:0] masterWdata,
	input wire logic masterWe,
	input wire logic [menuPkg::lcdAddrW-1:0] slaveRaddr,
	output logic [menuPkg::charW-1:0] slaveRdata,
	output logic [menuPkg::lcdAddrW-1:0] lcdWadd,
	output logic [menuPkg::charW-1:0] lcdDin,
	output logic lcdW,
	output logic editActive
);
	import menuPkg::*;

	// FSM to sequencer
	logic seqStart;
	logic seqDone;
	logic [srcW-1:0] seqSrc;
	logic [menuW-1:0] seqMenu;
	logic [lcdAddrW-1:0] seqFirst;
	logic [lcdAddrW-1:0] seqLast;
	logic [charW-1:0] editChar;
	// Sequencer to store
	logic [srcW-1:0] rdSrc;
	logic [menuW-1:0] rdMenu;
	logic [lcdAddrW-1:0] rdAddr;
	logic [charW-1:0] rdData;
	// FSM to slave RAM
	logic slaveWe;
	logic slaveClear;
	logic [lcdAddrW-1:0] slaveWaddr;
	logic [charW-1:0] slaveWdata;

	menuFsm uMenuFsm (
		.clk(clk),
		.rstN(rstN),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.rotaryBtn(rotaryBtn),
		.menuBtn(menuBtn),
		.seqDone(seqDone),
		.seqStart(seqStart),
		.seqSrc(seqSrc),
		.seqMenu(seqMenu),
		.seqFirst(seqFirst),
		.seqLast(seqLast),
		.editChar(editChar),
		.slaveWe(slaveWe),
		.slaveWaddr(slaveWaddr),
		.slaveWdata(slaveWdata),
		.slaveClear(slaveClear),
		.editActive(editActive)
	);

	lcdSequencer uLcdSequencer (
		.clk(clk),
		.rstN(rstN),
		.seqStart(seqStart),
		.seqSrc(seqSrc),
		.seqMenu(seqMenu),
		.seqFirst(seqFirst),
		.seqLast(seqLast),
		.editChar(editChar),
		.rdData(rdData),
		.rdSrc(rdSrc),
		.rdMenu(rdMenu),
		.rdAddr(rdAddr),
		.lcdWadd(lcdWadd),
		.lcdDin(lcdDin),
		.lcdW(lcdW),
		.seqDone(seqDone)
	);

	charStore uCharStore (
		.clk(clk),
		.rstN(rstN),
		.rdSrc(rdSrc),
		.rdMenu(rdMenu),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.masterWaddr(masterWaddr),
		.masterWdata(masterWdata),
		.masterWe(masterWe),
		.slaveWe(slaveWe),
		.slaveWaddr(slaveWaddr),
		.slaveWdata(slaveWdata),
		.slaveClear(slaveClear),
		.slaveRaddr(slaveRaddr),
		.slaveRdata(slaveRdata)
	);

endmodule

`default_nettype wire

/* menuCtrl_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module menuCtrlAssert (
	input wire logic clk,
	input wire logic rstN,
	input wire logic lcdW,
	input wire logic editActive
);

	// Failures so far, read by the testbench
	int failCount = 0;

	////////////////////
	// LCD write strobe
	////////////////////

	// Every character has a fetch cycle before its write
	writeGap: assert property (@(posedge clk) disable iff (!rstN) lcdW |=> !lcdW)
		else begin
			failCount++;
			$error("lcdW high on two cycles in a row");
		end

	// Sequencer is idle one edge into reset
	resetQuiet: assert property (@(posedge clk) !rstN |=> !lcdW)
		else begin
			failCount++;
			$error("lcdW high while reset is held");
		end

	// Position select never redraws the screen
	editNoWrite: assert property (@(posedge clk) disable iff (!rstN) !(lcdW && editActive))
		else begin
			failCount++;
			$error("lcdW high during position select");
		end

endmodule

`default_nettype wire

/* tb_menuCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_menuCtrl;
	import menuPkg::*;

	// Script tokens hold up to 16 characters
	localparam int tokW = 8 * 16;
	// Idle means this many cycles without an LCD write
	localparam int quietLen = 20;
	localparam int idleTimeout = 200;

	// Expected place in the menu
	localparam int modeMenu = 0;
	localparam int modeConfirm = 1;
	localparam int modeBack = 2;
	localparam int modePos = 3;
	localparam int modeChar = 4;
	// Options on the main ring
	localparam int optCount = 5;

	logic clk;
	logic rstN;
	logic rotaryEvent;
	logic rotaryLeft;
	logic rotaryBtn;
	logic menuBtn;
	logic [lcdAddrW-1:0] masterWaddr;
	logic [charW-1:0] masterWdata;
	logic masterWe;
	logic [lcdAddrW-1:0] slaveRaddr;
	logic [charW-1:0] slaveRdata;
	logic [lcdAddrW-1:0] lcdWadd;
	logic [charW-1:0] lcdDin;
	logic lcdW;
	logic editActive;

	// What the LCD shows, both lines
	logic [charW-1:0] shadow [screenLen];

	int errCount;
	int timeoutCount;
	bit timedOut;
	// Main option index, 0 is DISPLAY MASTER
	int expOpt;
	int expMode;

	menuCtrl u_menuCtrl (
		.clk(clk),
		.rstN(rstN),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.rotaryBtn(rotaryBtn),
		.menuBtn(menuBtn),
		.masterWaddr(masterWaddr),
		.masterWdata(masterWdata),
		.masterWe(masterWe),
		.slaveRaddr(slaveRaddr),
		.slaveRdata(slaveRdata),
		.lcdWadd(lcdWadd),
		.lcdDin(lcdDin),
		.lcdW(lcdW),
		.editActive(editActive)
	);

	bind menuCtrl menuCtrlAssert assertChecks (
		.clk(clk),
		.rstN(rstN),
		.lcdW(lcdW),
		.editActive(editActive)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (lcdW === 1'b1) begin
			shadow[lcdWadd] <= lcdDin;
		end
	end

	////////////////////
	// Token helpers
	////////////////////

	// Comment rows start with a hash
	function automatic bit isComment(input logic [tokW-1:0] tok);
		bit found;
		bit res;
		found = 1'b0;
		res = 1'b0;
		for (int k = tokW / charW - 1; k >= 0; k--) begin
			if (!found && tok[k*charW +: charW] != 8'h00) begin
				found = 1'b1;
				res = (tok[k*charW +: charW] == "#");
			end
		end
		return res;
	endfunction

	// Column of the expected text, underscore stands for a space
	function automatic logic [charW-1:0] lineChar(input logic [tokW-1:0] tok, input int col);
		int len;
		logic [charW-1:0] c;
		len = 0;
		for (int k = 0; k < tokW / charW; k++) begin
			if (tok[k*charW +: charW] != 8'h00) begin
				len = k + 1;
			end
		end
		c = (col < len) ? tok[(len-1-col)*charW +: charW] : spaceChar;
		if (c == "_") begin
			c = spaceChar;
		end
		return c;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	task automatic waitIdle(input logic [tokW-1:0] name);
		int cycles;
		int quiet;
		cycles = 0;
		quiet = 0;
		while (quiet < quietLen && cycles < idleTimeout) begin
			@(negedge clk);
			quiet = lcdW ? 0 : quiet + 1;
			cycles++;
		end
		if (quiet < quietLen) begin
			$display("%0s: LCD still busy after %0d cycles", name, idleTimeout);
			timeoutCount++;
			timedOut = 1'b1;
		end
	endtask

	// One-cycle pulse, like the debouncer output
	task automatic pulseInputs(input logic rot, input logic left, input logic btn,
			input logic menu);
		@(posedge clk);
		rotaryEvent <= rot;
		rotaryLeft <= left;
		rotaryBtn <= btn;
		menuBtn <= menu;
		@(posedge clk);
		rotaryEvent <= 1'b0;
		rotaryBtn <= 1'b0;
		menuBtn <= 1'b0;
	endtask

	// Master writes base plus address into every cell
	task automatic fillMaster(input logic [charW-1:0] base);
		for (int i = 0; i < screenLen; i++) begin
			@(posedge clk);
			masterWe <= 1'b1;
			masterWaddr <= lcdAddrW'(i);
			masterWdata <= base + charW'(i);
		end
		@(posedge clk);
		masterWe <= 1'b0;
	endtask

	task automatic readSlave(input logic [lcdAddrW-1:0] addr, output logic [charW-1:0] data);
		@(posedge clk);
		slaveRaddr <= addr;
		@(negedge clk);
		data = slaveRdata;
	endtask

	// Where the menu should be after one user action
	task automatic predictMode(input logic [tokW-1:0] act);
		case (act)
			// Rotation moves the option only on the main menu
			tokW'("rotL"), tokW'("rotR"): begin
				if (expMode == modeMenu && act == tokW'("rotL")) begin
					expOpt = (expOpt + 1) % optCount;
				end else if (expMode == modeMenu) begin
					expOpt = (expOpt + optCount - 1) % optCount;
				end
			end
			tokW'("btn"):
				case (expMode)
					modeMenu:
						case (expOpt)
							0, 1: expMode = modeBack;
							2: expMode = modePos;
							3: expMode = modeConfirm;
							default: ;
						endcase
					modeConfirm: begin
						expMode = modeMenu;
						expOpt = 0;
					end
					modeBack:
						expMode = modeMenu;
					modePos:
						expMode = modeChar;
					default:
						expMode = modePos;
				endcase
			tokW'("menu"): begin
				expMode = modeMenu;
				expOpt = 0;
			end
			default: ;
		endcase
	endtask

	////////////////////
	// Checks
	////////////////////

	task automatic checkByte(input logic [tokW-1:0] name, input logic [charW-1:0] exp,
			input logic [charW-1:0] got);
		assert (got === exp) else begin
			$display("ERROR %0s: expected %h, actual %h", name, exp, got);
			errCount++;
		end
	endtask

	// Edit flag is high only in position select
	task automatic checkEdit(input logic [tokW-1:0] name);
		logic exp;
		exp = (expMode == modePos);
		assert (editActive === exp) else begin
			$display("ERROR %0s: expected editActive %b, actual %b", name, exp, editActive);
			errCount++;
		end
	endtask

	task automatic checkLine(input logic [tokW-1:0] name, input int row,
			input logic [tokW-1:0] text);
		logic [charW*lineLen-1:0] exp;
		logic [charW*lineLen-1:0] got;
		for (int j = 0; j < lineLen; j++) begin
			exp[(lineLen-1-j)*charW +: charW] = lineChar(text, j);
			got[(lineLen-1-j)*charW +: charW] = shadow[lcdAddrW'(row * lineLen + j)];
		end
		assert (got === exp) else begin
			$display("ERROR %0s: expected \"%s\", actual \"%s\"", name, exp, got);
			errCount++;
		end
	endtask

	// One row of the script
	task automatic runStep(input logic [tokW-1:0] name, input logic [tokW-1:0] act,
			input logic [charW-1:0] arg, input logic [charW-1:0] val,
			input logic [tokW-1:0] text);
		logic [charW-1:0] got;
		case (act)
			tokW'("rotL"): begin
				pulseInputs(1'b1, 1'b1, 1'b0, 1'b0);
				waitIdle(name);
				predictMode(act);
				checkEdit(name);
			end
			tokW'("rotR"): begin
				pulseInputs(1'b1, 1'b0, 1'b0, 1'b0);
				waitIdle(name);
				predictMode(act);
				checkEdit(name);
			end
			tokW'("btn"): begin
				pulseInputs(1'b0, 1'b0, 1'b1, 1'b0);
				waitIdle(name);
				predictMode(act);
				checkEdit(name);
			end
			tokW'("menu"): begin
				pulseInputs(1'b0, 1'b0, 1'b0, 1'b1);
				waitIdle(name);
				predictMode(act);
				checkEdit(name);
			end
			tokW'("mfill"):
				fillMaster(arg);
			tokW'("line1"):
				checkLine(name, 0, text);
			tokW'("line2"):
				checkLine(name, 1, text);
			// Whole screen against the master fill pattern
			tokW'("screen"):
				for (int i = 0; i < screenLen; i++) begin
					checkByte(name, arg + charW'(i), shadow[i]);
				end
			tokW'("cell"):
				checkByte(name, val, shadow[arg[lcdAddrW-1:0]]);
			tokW'("slave"): begin
				readSlave(arg[lcdAddrW-1:0], got);
				checkByte(name, val, got);
			end
			tokW'("slaveall"):
				for (int i = 0; i < screenLen; i++) begin
					readSlave(lcdAddrW'(i), got);
					checkByte(name, val, got);
				end
			default: begin
				$display("%0s: the test file names an unknown action", name);
				errCount++;
			end
		endcase
	endtask

	////////////////////
	// Script player
	////////////////////

	initial begin
		int fd;
		int n;
		bit done;
		logic [tokW-1:0] nameTok;
		logic [tokW-1:0] actTok;
		logic [tokW-1:0] argTok;
		logic [tokW-1:0] valTok;
		logic [tokW-1:0] textTok;
		logic [charW-1:0] arg;
		logic [charW-1:0] val;
		rstN = 1'b0;
		rotaryEvent = 1'b0;
		rotaryLeft = 1'b0;
		rotaryBtn = 1'b0;
		menuBtn = 1'b0;
		masterWaddr = '0;
		masterWdata = '0;
		masterWe = 1'b0;
		slaveRaddr = '0;
		errCount = 0;
		timeoutCount = 0;
		timedOut = 1'b0;
		expOpt = 0;
		expMode = modeMenu;
		done = 1'b0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		// First refresh after reset
		waitIdle(tokW'("reset"));
		checkEdit(tokW'("reset"));
		fd = $fopen("menuCtrl_tests.txt", "r");
		if (fd == 0) begin
			$display("The test file menuCtrl_tests.txt could not be opened");
			errCount++;
			done = 1'b1;
		end
		while (!done && !timedOut) begin
			nameTok = '0;
			actTok = '0;
			argTok = '0;
			valTok = '0;
			textTok = '0;
			n = $fscanf(fd, "%s %s %s %s %s", nameTok, actTok, argTok, valTok, textTok);
			if (n != 5) begin
				done = 1'b1;
			end else if (!isComment(nameTok)) begin
				arg = '0;
				val = '0;
				n = $sscanf(argTok, "%h", arg);
				n = $sscanf(valTok, "%h", val);
				runStep(nameTok, actTok, arg, val, textTok);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("errors: %0d check, %0d timeout, %0d assertion", errCount, timeoutCount,
			u_menuCtrl.assertChecks.failCount);
		if (errCount == 0 && timeoutCount == 0 && u_menuCtrl.assertChecks.failCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* menuCtrl_tests.txt */
#name action arg value text
boot line1 0 0 MAIN_MENU
boot line2 0 0 DISPLAY_MASTER
ringFwd rotL 0 0 -
ringFwd line2 0 0 DISPLAY_RAM
ringFwd rotL 0 0 -
ringFwd line2 0 0 MODIFY_RAM
ringFwd rotL 0 0 -
ringFwd line2 0 0 CLEAR_RAM
ringFwd rotL 0 0 -
ringFwd line2 0 0 SLAVE_ACTIONS
slaveAct btn 0 0 -
slaveAct line2 0 0 SLAVE_ACTIONS
ringWrap rotL 0 0 -
ringWrap line1 0 0 MAIN_MENU
ringWrap line2 0 0 DISPLAY_MASTER
ringBack rotR 0 0 -
ringBack line2 0 0 SLAVE_ACTIONS
ringBack rotR 0 0 -
ringBack line2 0 0 CLEAR_RAM
ringBack rotR 0 0 -
ringBack line2 0 0 MODIFY_RAM
ringBack rotR 0 0 -
ringBack line2 0 0 DISPLAY_RAM
ringBack rotR 0 0 -
ringBack line2 0 0 DISPLAY_MASTER
master mfill 30 0 -
master btn 0 0 -
master screen 30 0 -
masterBack btn 0 0 -
masterBack line1 0 0 MAIN_MENU
masterBack line2 0 0 DISPLAY_MASTER
modify rotL 0 0 -
modify rotL 0 0 -
modify btn 0 0 -
modify cell 3 20 -
modify rotL 0 0 -
modify rotL 0 0 -
modify rotL 0 0 -
modify btn 0 0 -
modify rotL 0 0 -
modify rotL 0 0 -
modify cell 3 43 -
modify btn 0 0 -
modify slave 3 43 -
modify slave 2 20 -
menuKey menu 0 0 -
menuKey line1 0 0 MAIN_MENU
menuKey line2 0 0 DISPLAY_MASTER
clearNo rotR 0 0 -
clearNo rotR 0 0 -
clearNo btn 0 0 -
clearNo line1 0 0 ARE_YOU_SURE?
clearNo line2 0 0 YES
clearNo rotL 0 0 -
clearNo line2 0 0 NO
clearNo btn 0 0 -
clearNo line1 0 0 MAIN_MENU
clearNo slave 3 43 -
clearYes rotR 0 0 -
clearYes rotR 0 0 -
clearYes btn 0 0 -
clearYes btn 0 0 -
clearYes slaveall 0 20 -
clearYes line2 0 0 DISPLAY_MASTER
menuShow btn 0 0 -
menuShow menu 0 0 -
menuShow line1 0 0 MAIN_MENU
menuShow line2 0 0 DISPLAY_MASTER

/* menuCtrl.f */
menuPkg.sv
menuRom.sv
charRam.sv
charStore.sv
lcdSequencer.sv
menuFsm.sv
menuCtrl.sv
menuCtrl_assert.sv
tb_menuCtrl.sv

/* run.sh */
#!/bin/sh
# Build and run the menu controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_menuCtrl -f menuCtrl.f
./obj_dir/Vtb_menuCtrl +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
